// File: axi_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4 side types for the AXI to SIF bridge
// Channel structs, burst encoding, response codes and
// the shared burst address step
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package axi_pkg;

  // Default ID width, top level ID_WIDTH must match
  localparam int ID_W = 4;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_e;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // Address channel, shared by AR and AW
  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [31:0]     addr;
    logic [7:0]      len;
    logic [2:0]      size;
    burst_e          burst;
  } axi_ar_t;

  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  strb;
    logic        last;
  } axi_w_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [63:0]     data;
    logic [1:0]      resp;
    logic            last;
  } axi_r_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } axi_b_t;

  // Next beat address, WRAP treated as INCR
  function automatic logic [31:0] next_addr(input logic [31:0] addr,
                                            input logic [2:0]  size,
                                            input burst_e      burst);
    logic [31:0] step;
    step = 32'd1 << size;
    if (burst == FIXED) begin
      return addr;
    end
    return addr + step;
  endfunction

endpackage

// File: sif_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Simple memory interface types
// Request and response words plus the arbiter owner
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package sif_pkg;

  // en is held as a request until granted
  typedef struct packed {
    logic        en;
    logic        we;
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [7:0]  wstrb;
  } sif_req_t;

  // rvalid pulses one cycle after a granted read
  typedef struct packed {
    logic [63:0] rdata;
    logic        rvalid;
  } sif_rsp_t;

  typedef enum logic {
    OWN_RD = 1'b0,
    OWN_WR = 1'b1
  } owner_e;

endpackage

// File: axi_sif_read.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4 read engine
// Walks one AR burst as single-word SIF reads and
// returns each word as a registered R beat
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module axi_sif_read #(
  parameter int ID_WIDTH = 4
) (
  input  logic               ACLK,
  input  logic               ARESETn,

  input  axi_pkg::axi_ar_t   ar,
  input  logic               ar_valid,
  output logic               ar_ready,

  output axi_pkg::axi_r_t    r,
  output logic               r_valid,
  input  logic               r_ready,

  output sif_pkg::sif_req_t  req,
  input  logic               gnt,
  input  sif_pkg::sif_rsp_t  rsp
);

  import axi_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT,
    BEAT
  } state_e;

  state_e              state_q;
  logic [7:0]          beat_q;
  logic                last_q;

  logic [ID_WIDTH-1:0] id_q;
  logic [31:0]         addr_q;
  logic [7:0]          len_q;
  logic [2:0]          size_q;
  burst_e              burst_q;
  logic [63:0]         rdata_q;

  logic                ar_hs;
  logic                r_hs;

  assign ar_hs = ar_valid && ar_ready;
  assign r_hs  = r_valid && r_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Burst FSM, one beat in flight at a time
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state_q <= IDLE;
      beat_q  <= '0;
      last_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (ar_hs) begin
            beat_q  <= '0;
            state_q <= REQ;
          end
        end
        REQ: begin
          if (gnt) begin
            state_q <= WAIT;
          end
        end
        WAIT: begin
          if (rsp.rvalid) begin
            last_q  <= (beat_q == len_q);
            state_q <= BEAT;
          end
        end
        BEAT: begin
          // Next SIF read only after this beat is taken
          if (r_hs) begin
            if (last_q) begin
              state_q <= IDLE;
            end else begin
              beat_q  <= beat_q + 8'd1;
              state_q <= REQ;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Captured burst fields and the returned word
  always_ff @(posedge ACLK) begin
    if (ar_hs) begin
      id_q    <= ar.id;
      addr_q  <= ar.addr;
      len_q   <= ar.len;
      size_q  <= ar.size;
      burst_q <= ar.burst;
    end else if (state_q == REQ && gnt) begin
      addr_q  <= next_addr(addr_q, size_q, burst_q);
    end
    if (state_q == WAIT && rsp.rvalid) begin
      rdata_q <= rsp.rdata;
    end
  end

  assign ar_ready = (state_q == IDLE);
  assign r_valid  = (state_q == BEAT);

  always_comb begin
    r.id       = id_q;
    r.data     = rdata_q;
    r.resp     = RESP_OKAY;
    r.last     = last_q;

    req.en     = (state_q == REQ);
    req.we     = 1'b0;
    req.addr   = addr_q;
    req.wdata  = '0;
    req.wstrb  = '0;
  end

endmodule

// File: axi_sif_write.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4 write engine
// Turns each W beat of an AW burst into one SIF write
// and answers with B after the last beat is granted
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module axi_sif_write #(
  parameter int ID_WIDTH = 4
) (
  input  logic               ACLK,
  input  logic               ARESETn,

  input  axi_pkg::axi_ar_t   aw,
  input  logic               aw_valid,
  output logic               aw_ready,

  input  axi_pkg::axi_w_t    w,
  input  logic               w_valid,
  output logic               w_ready,

  output axi_pkg::axi_b_t    b,
  output logic               b_valid,
  input  logic               b_ready,

  output sif_pkg::sif_req_t  req,
  input  logic               gnt
);

  import axi_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    DATA,
    MEM,
    RESP
  } state_e;

  state_e              state_q;
  logic                last_q;

  logic [ID_WIDTH-1:0] id_q;
  logic [31:0]         addr_q;
  logic [2:0]          size_q;
  burst_e              burst_q;
  logic [63:0]         wdata_q;
  logic [7:0]          wstrb_q;

  logic                aw_hs;
  logic                w_hs;
  logic                mem_done;

  assign aw_hs    = aw_valid && aw_ready;
  assign w_hs     = w_valid && w_ready;
  assign mem_done = (state_q == MEM) && gnt;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Burst FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state_q <= IDLE;
      last_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (aw_hs) begin
            state_q <= DATA;
          end
        end
        DATA: begin
          if (w_hs) begin
            last_q  <= w.last;
            state_q <= MEM;
          end
        end
        MEM: begin
          // SRAM write completes at the grant edge
          if (gnt) begin
            state_q <= last_q ? RESP : DATA;
          end
        end
        RESP: begin
          if (b_ready) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Burst fields and the pending beat
  always_ff @(posedge ACLK) begin
    if (aw_hs) begin
      id_q    <= aw.id;
      addr_q  <= aw.addr;
      size_q  <= aw.size;
      burst_q <= aw.burst;
    end else if (mem_done) begin
      addr_q  <= next_addr(addr_q, size_q, burst_q);
    end
    if (w_hs) begin
      wdata_q <= w.data;
      wstrb_q <= w.strb;
    end
  end

  assign aw_ready = (state_q == IDLE);
  assign w_ready  = (state_q == DATA);
  assign b_valid  = (state_q == RESP);

  always_comb begin
    b.id      = id_q;
    b.resp    = RESP_OKAY;

    req.en    = (state_q == MEM);
    req.we    = 1'b1;
    req.addr  = addr_q;
    req.wdata = wdata_q;
    req.wstrb = wstrb_q;
  end

endmodule

// File: sif_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin SIF arbiter
// Grants one engine per cycle, forwards its request to
// memory and steers read data back to the read engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module sif_arbiter (
  input  logic               ACLK,
  input  logic               ARESETn,

  input  sif_pkg::sif_req_t  rd_req,
  input  sif_pkg::sif_req_t  wr_req,
  output logic               rd_gnt,
  output logic               wr_gnt,

  output sif_pkg::sif_req_t  mem_req,
  input  sif_pkg::sif_rsp_t  mem_rsp,
  output sif_pkg::sif_rsp_t  rd_rsp
);

  import sif_pkg::*;

  owner_e last_q;

  // On a tie the engine not granted last wins
  assign rd_gnt = rd_req.en && (!wr_req.en || last_q == OWN_WR);
  assign wr_gnt = wr_req.en && !rd_gnt;

  // The granted request goes straight to memory
  // With no grant the read request passes with en low
  assign mem_req = wr_gnt ? wr_req : rd_req;

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      last_q <= OWN_WR;
    end else if (rd_gnt || wr_gnt) begin
      last_q <= rd_gnt ? OWN_RD : OWN_WR;
    end
  end

  // Read data belongs to whoever held the last grant
  assign rd_rsp.rdata  = mem_rsp.rdata;
  assign rd_rsp.rvalid = mem_rsp.rvalid && (last_q == OWN_RD);

endmodule

// File: sif_sram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port 64-bit synchronous SRAM
// Byte strobed writes, read data one cycle after request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module sif_sram #(
  parameter int MEM_WORDS = 256
) (
  input  logic               ACLK,
  input  sif_pkg::sif_req_t  req,
  output sif_pkg::sif_rsp_t  rsp
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [63:0]      mem [MEM_WORDS];
  logic [31:0]      word_no;
  logic [IDX_W-1:0] idx;
  logic [63:0]      rdata_q;
  logic             rvalid_q;

  // Byte address to word index, wrapping at the depth
  assign word_no = {3'b000, req.addr[31:3]} % 32'(MEM_WORDS);
  assign idx     = IDX_W'(word_no);

  always_ff @(posedge ACLK) begin
    for (int i = 0; i < 8; i++) begin
      if (req.en && req.we && req.wstrb[i]) begin
        mem[idx][i*8 +: 8] <= req.wdata[i*8 +: 8];
      end
    end
    if (req.en && !req.we) begin
      rdata_q <= mem[idx];
    end
    rvalid_q <= req.en && !req.we;
  end

  assign rsp.rdata  = rdata_q;
  assign rsp.rvalid = rvalid_q;

endmodule

// File: axi_sif_bridge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4 slave to SIF bridge, top level
// Read and write engines share one SRAM through a
// round-robin arbiter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module axi_sif_bridge #(
  parameter int ID_WIDTH  = 4,
  parameter int MEM_WORDS = 256
) (
  input  logic              ACLK,
  input  logic              ARESETn,

  input  axi_pkg::axi_ar_t  ar,
  input  logic              ar_valid,
  output logic              ar_ready,
  output axi_pkg::axi_r_t   r,
  output logic              r_valid,
  input  logic              r_ready,

  input  axi_pkg::axi_ar_t  aw,
  input  logic              aw_valid,
  output logic              aw_ready,
  input  axi_pkg::axi_w_t   w,
  input  logic              w_valid,
  output logic              w_ready,
  output axi_pkg::axi_b_t   b,
  output logic              b_valid,
  input  logic              b_ready
);

  import sif_pkg::*;

  sif_req_t rd_req;
  sif_req_t wr_req;
  sif_req_t mem_req;
  sif_rsp_t mem_rsp;
  sif_rsp_t rd_rsp;
  logic     rd_gnt;
  logic     wr_gnt;

  axi_sif_read #(.ID_WIDTH(ID_WIDTH)) u_read (
    .ACLK     (ACLK),
    .ARESETn  (ARESETn),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .req      (rd_req),
    .gnt      (rd_gnt),
    .rsp      (rd_rsp)
  );

  axi_sif_write #(.ID_WIDTH(ID_WIDTH)) u_write (
    .ACLK     (ACLK),
    .ARESETn  (ARESETn),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .req      (wr_req),
    .gnt      (wr_gnt)
  );

  sif_arbiter u_arbiter (
    .ACLK     (ACLK),
    .ARESETn  (ARESETn),
    .rd_req   (rd_req),
    .wr_req   (wr_req),
    .rd_gnt   (rd_gnt),
    .wr_gnt   (wr_gnt),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp),
    .rd_rsp   (rd_rsp)
  );

  sif_sram #(.MEM_WORDS(MEM_WORDS)) u_sram (
    .ACLK     (ACLK),
    .req      (mem_req),
    .rsp      (mem_rsp)
  );

endmodule

// File: tb_axi_sif_bridge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for the AXI to SIF bridge
// Runs the bursts listed in axi_sif_testdata.txt and checks
// every R and B response against a shadow memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_axi_sif_bridge;

  import axi_pkg::*;

  localparam int MEM_WORDS = 256;
  localparam int MAX_OPS   = 32;
  // ASCII codes used by the file parser
  localparam int CH_HASH   = 35;
  localparam int CH_NL     = 10;

  logic    ACLK = 1'b0;
  logic    ARESETn;
  axi_ar_t ar;
  logic    ar_valid;
  logic    ar_ready;
  axi_r_t  r;
  logic    r_valid;
  logic    r_ready;
  axi_ar_t aw;
  logic    aw_valid;
  logic    aw_ready;
  axi_w_t  w;
  logic    w_valid;
  logic    w_ready;
  axi_b_t  b;
  logic    b_valid;
  logic    b_ready;

  // Parsed test list
  logic [7:0]      op_a    [MAX_OPS];
  logic [ID_W-1:0] id_a    [MAX_OPS];
  logic [31:0]     addr_a  [MAX_OPS];
  logic [7:0]      len_a   [MAX_OPS];
  logic [2:0]      size_a  [MAX_OPS];
  logic [1:0]      burst_a [MAX_OPS];
  logic            stall_a [MAX_OPS];
  int              n_ops;
  int              limit_cycles;
  logic            loaded;

  // Shadow memory and the bytes written so far
  logic [63:0]     shadow [MEM_WORDS];
  logic [7:0]      known  [MEM_WORDS];

  integer          seed;
  logic            stall_on;

  axi_sif_bridge #(.ID_WIDTH(ID_W), .MEM_WORDS(MEM_WORDS)) dut_i (
    .ACLK     (ACLK),
    .ARESETn  (ARESETn),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready)
  );

  always #2 ACLK = ~ACLK;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference rules and reporting
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic int word_index(input logic [31:0] addr);
    return int'((addr / 32'd8) % 32'(MEM_WORDS));
  endfunction

  // FIXED keeps the address, INCR and WRAP advance by the transfer size
  function automatic logic [31:0] step_addr(input logic [31:0] addr,
                                            input logic [2:0]  size,
                                            input logic [1:0]  burst);
    if (burst_e'(burst) == FIXED) begin
      return addr;
    end
    return addr + (32'd1 << size);
  endfunction

  function automatic logic is_space(input int c);
    return (c == 32) || (c == 9) || (c == CH_NL) || (c == 13);
  endfunction

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("error: time %0t, %s expected %h actual %h", $time, name, expected, actual);
      report_failure("stopping at the first mismatch");
    end
  endtask

  task automatic load_tests();
    int              fd;
    int              c;
    int              got;
    int              beats;
    logic [ID_W-1:0] f_id;
    logic [31:0]     f_addr;
    logic [7:0]      f_len;
    logic [2:0]      f_size;
    logic [1:0]      f_burst;
    logic            f_stall;
    fd = $fopen("axi_sif_testdata.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open the test data file axi_sif_testdata.txt");
    end
    n_ops = 0;
    beats = 0;
    c = $fgetc(fd);
    while (c != -1) begin
      if (is_space(c)) begin
        c = $fgetc(fd);
      end else if (c == CH_HASH) begin
        while (c != -1 && c != CH_NL) begin
          c = $fgetc(fd);
        end
      end else begin
        got = $fscanf(fd, "%h %h %h %h %h %h", f_id, f_addr, f_len, f_size, f_burst, f_stall);
        if (got != 6 || n_ops == MAX_OPS || !(8'(c) inside {"W", "R", "P"})) begin
          report_failure("the test data file has a bad line or too many lines");
        end
        op_a[n_ops]    = 8'(c);
        id_a[n_ops]    = f_id;
        addr_a[n_ops]  = f_addr;
        len_a[n_ops]   = f_len;
        size_a[n_ops]  = f_size;
        burst_a[n_ops] = f_burst;
        stall_a[n_ops] = f_stall;
        beats += (int'(f_len) + 1) * ((8'(c) == "P") ? 2 : 1);
        n_ops++;
        c = $fgetc(fd);
      end
    end
    $fclose(fd);
    limit_cycles = 200 * beats + 20;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Burst drivers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic drive_readies();
    forever begin
      @(posedge ACLK);
      r_ready <= stall_on ? 1'($random(seed)) : 1'b1;
      b_ready <= stall_on ? 1'($random(seed)) : 1'b1;
    end
  endtask

  task automatic run_write(input logic [ID_W-1:0] id, input logic [31:0] addr,
                           input logic [7:0] len, input logic [2:0] size,
                           input logic [1:0] burst);
    axi_ar_t     cmd;
    axi_w_t      beat;
    logic [31:0] cur;
    int          idx;
    cmd.id    = id;
    cmd.addr  = addr;
    cmd.len   = len;
    cmd.size  = size;
    cmd.burst = burst_e'(burst);
    aw       <= cmd;
    aw_valid <= 1'b1;
    @(posedge ACLK);
    while (!aw_ready) begin
      @(posedge ACLK);
    end
    aw_valid <= 1'b0;
    cur = addr;
    for (int i = 0; i <= int'(len); i++) begin
      // Bytes never written get full strobes so later reads see known data
      idx       = word_index(cur);
      beat.data = {32'($random(seed)), 32'($random(seed))};
      beat.strb = 8'($random(seed)) | ~known[idx];
      beat.last = (i == int'(len));
      for (int j = 0; j < 8; j++) begin
        if (beat.strb[j]) begin
          shadow[idx][j*8 +: 8] = beat.data[j*8 +: 8];
        end
      end
      known[idx] = 8'hFF;
      w       <= beat;
      w_valid <= 1'b1;
      @(posedge ACLK);
      while (!w_ready) begin
        @(posedge ACLK);
      end
      check_value("b_valid during W", 64'd0, 64'(b_valid));
      cur = step_addr(cur, size, burst);
    end
    w_valid <= 1'b0;
    @(posedge ACLK);
    while (!(b_valid && b_ready)) begin
      @(posedge ACLK);
    end
    check_value("b.id", 64'(id), 64'(b.id));
    check_value("b.resp", 64'(RESP_OKAY), 64'(b.resp));
    @(posedge ACLK);
    check_value("aw_ready", 64'd1, 64'(aw_ready));
  endtask

  task automatic run_read(input logic [ID_W-1:0] id, input logic [31:0] addr,
                          input logic [7:0] len, input logic [2:0] size,
                          input logic [1:0] burst);
    axi_ar_t     cmd;
    logic [31:0] cur;
    cmd.id    = id;
    cmd.addr  = addr;
    cmd.len   = len;
    cmd.size  = size;
    cmd.burst = burst_e'(burst);
    ar       <= cmd;
    ar_valid <= 1'b1;
    @(posedge ACLK);
    while (!ar_ready) begin
      @(posedge ACLK);
    end
    ar_valid <= 1'b0;
    cur = addr;
    for (int i = 0; i <= int'(len); i++) begin
      @(posedge ACLK);
      while (!(r_valid && r_ready)) begin
        @(posedge ACLK);
      end
      check_value("r.data", shadow[word_index(cur)], r.data);
      check_value("r.last", 64'(i == int'(len)), 64'(r.last));
      check_value("r.id", 64'(id), 64'(r.id));
      check_value("r.resp", 64'(RESP_OKAY), 64'(r.resp));
      cur = step_addr(cur, size, burst);
    end
    // No extra beat, engine idle again
    @(posedge ACLK);
    check_value("r_valid after last", 64'd0, 64'(r_valid));
    check_value("ar_ready", 64'd1, 64'(ar_ready));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Main sequence and watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    ARESETn  = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    r_ready  = 1'b0;
    b_ready  = 1'b0;
    seed     = 43487;
    stall_on = 1'b0;
    loaded   = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = 'x;
      known[i]  = '0;
    end
    load_tests();
    loaded = 1'b1;
    repeat (10) @(posedge ACLK);
    ARESETn <= 1'b1;
    @(posedge ACLK);
    check_value("ar_ready", 64'd1, 64'(ar_ready));
    check_value("aw_ready", 64'd1, 64'(aw_ready));
    check_value("r_valid", 64'd0, 64'(r_valid));
    check_value("w_ready", 64'd0, 64'(w_ready));
    check_value("b_valid", 64'd0, 64'(b_valid));
    fork
      drive_readies();
    join_none
    for (int i = 0; i < n_ops; i++) begin
      stall_on <= stall_a[i];
      case (op_a[i])
        "W": run_write(id_a[i], addr_a[i], len_a[i], size_a[i], burst_a[i]);
        "R": run_read(id_a[i], addr_a[i], len_a[i], size_a[i], burst_a[i]);
        default: begin
          // Read side uses the far half of memory and the next id
          fork
            run_write(id_a[i], addr_a[i], len_a[i], size_a[i], burst_a[i]);
            run_read(id_a[i] + 1'b1, addr_a[i] ^ 32'h400, len_a[i], size_a[i], burst_a[i]);
          join
        end
      endcase
    end
    $display("** PASS **");
    $finish;
  end

  initial begin
    wait (loaded === 1'b1);
    repeat (limit_cycles) @(posedge ACLK);
    report_failure("timeout, the bursts did not complete within the cycle budget");
  end

endmodule

// File: axi_sif_testdata.txt
# op id addr len size burst stall, all numbers hex
# op W write, R read, P write at addr with read of id+1 at addr^400
# size is log2 of bytes, burst 0 FIXED 1 INCR 2 WRAP, stall randomizes r_ready and b_ready
W 1 00000000 07 3 1 0
R 2 00000000 07 3 1 0
W 3 00000040 03 3 0 0
R 4 00000040 03 3 0 0
W 5 00000080 0f 1 1 0
R 6 00000080 0f 1 1 0
W 7 00000000 07 3 1 1
R 8 00000000 07 3 1 1
W 9 00000400 0f 3 1 0
W a 00000480 07 2 2 0
P b 00000000 0f 3 1 1
P d 00000480 07 2 1 1
R e 00000000 0f 3 1 0
R f 00000480 07 2 2 1
R 3 00000040 00 3 0 1
W 0 00000100 00 3 1 0
R 1 00000100 00 3 1 1

// File: verilog.f
axi_pkg.sv
sif_pkg.sv
axi_sif_read.sv
axi_sif_write.sv
sif_arbiter.sv
sif_sram.sv
axi_sif_bridge.sv
tb_axi_sif_bridge.sv

// File: Makefile
# Verilator build and run of the AXI to SIF bridge testbench

.PHONY: run clean

obj_dir/Vtb_axi_sif_bridge: verilog.f $(shell cat verilog.f)
	verilator --binary --timing --timescale 1ns/1ns --top-module tb_axi_sif_bridge -f verilog.f

run: obj_dir/Vtb_axi_sif_bridge
	./obj_dir/Vtb_axi_sif_bridge | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
